//--- pic_alu_settings.svh
// Widths and opcode encodings for the accumulator ALU
// Opcodes are matched against the top bits of the 14-bit word
// Five- and four-bit codes leave the remaining opcode bits as don't-care
`ifndef PIC_ALU_SETTINGS_SVH
`define PIC_ALU_SETTINGS_SVH

`define PIC_DATA_W      8
`define PIC_INSTR_W     14
`define PIC_FADDR_W     7
`define PIC_FILE_DEPTH  128
`define PIC_BIT_W       3

// Byte-oriented, bits [13:8]
`define PIC_OP_ADDWF    6'b000111
`define PIC_OP_ANDWF    6'b000101
`define PIC_OP_CLR      6'b000001
`define PIC_OP_COMF     6'b001001
`define PIC_OP_DECF     6'b000011
`define PIC_OP_INCF     6'b001010
`define PIC_OP_IORWF    6'b000100
`define PIC_OP_MOVF     6'b001000
`define PIC_OP_MOVWF    6'b000000
`define PIC_OP_RLF      6'b001101
`define PIC_OP_RRF      6'b001100
`define PIC_OP_SUBWF    6'b000010
`define PIC_OP_SWAPF    6'b001110
`define PIC_OP_XORWF    6'b000110

// Literal logic, bits [13:8]
`define PIC_OP_XORLW    6'b111010
`define PIC_OP_ANDLW    6'b111001
`define PIC_OP_IORLW    6'b111000

// Literal arithmetic, bits [13:9]
`define PIC_OP_ADDLW    5'b11111
`define PIC_OP_SUBLW    5'b11110

// Bits [13:10]
`define PIC_OP_MOVLW    4'b1100
`define PIC_OP_BCF      4'b0100
`define PIC_OP_BSF      4'b0101

`endif

//--- pic_alu_pkg.sv
// Shared types of the ALU pipeline
// STATUS only holds Z, DC and C, in the usual bit order 2..0
// The micro-op literal field carries the bit index for BCF and BSF
`include "pic_alu_settings.svh"

package pic_alu_pkg;

    // Byte-oriented view
    typedef struct packed {
        logic [5:0]              op;
        logic                    d;     // 0 to W, 1 to file
        logic [`PIC_FADDR_W-1:0] f;
    } byte_fmt_t;

    // Bit-oriented view
    typedef struct packed {
        logic [3:0]              op;
        logic [`PIC_BIT_W-1:0]   b;
        logic [`PIC_FADDR_W-1:0] f;
    } bit_fmt_t;

    // Literal view
    typedef struct packed {
        logic [5:0]             op;
        logic [`PIC_DATA_W-1:0] k;
    } lit_fmt_t;

    // One word, three decodings
    typedef union packed {
        byte_fmt_t bytef;
        bit_fmt_t  bitf;
        lit_fmt_t  litf;
    } instr_t;

    typedef enum logic [4:0] {
        ALU_NOP,
        ALU_ADDWF,
        ALU_ANDWF,
        ALU_CLRF,
        ALU_CLRW,
        ALU_COMF,
        ALU_DECF,
        ALU_INCF,
        ALU_IORWF,
        ALU_MOVF,
        ALU_MOVWF,
        ALU_RLF,
        ALU_RRF,
        ALU_SUBWF,
        ALU_SWAPF,
        ALU_XORWF,
        ALU_BCF,
        ALU_BSF,
        ALU_MOVLW,
        ALU_ADDLW,
        ALU_SUBLW,
        ALU_ANDLW,
        ALU_IORLW,
        ALU_XORLW
    } alu_op_e;

    typedef struct packed {
        alu_op_e                 op;
        logic                    dest_f;  // Result goes to the file register
        logic [`PIC_FADDR_W-1:0] addr;
        logic [`PIC_DATA_W-1:0]  lit;     // Literal, or bit index
        logic                    valid;
    } uop_t;

    typedef struct packed {
        uop_t                   uop;
        logic [`PIC_DATA_W-1:0] operand;  // File value after bypass
    } exec_t;

    typedef struct packed {
        logic z;
        logic dc;
        logic c;
    } status_t;

    typedef struct packed {
        logic                    en;
        logic [`PIC_FADDR_W-1:0] addr;
        logic [`PIC_DATA_W-1:0]  data;
    } file_wr_t;

endpackage

//--- file_regs.sv
// 128 x 8 file register array
// Read is combinational, write takes effect at the clock edge
// Every location clears on asynchronous reset
`timescale 1ns/1ps
`include "pic_alu_settings.svh"

module file_regs (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [`PIC_FADDR_W-1:0]  rd_addr,
    output logic [`PIC_DATA_W-1:0]   rd_data,
    input  pic_alu_pkg::file_wr_t    wr
);

    logic [`PIC_DATA_W-1:0] mem [`PIC_FILE_DEPTH];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `PIC_FILE_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (wr.en) begin
            mem[wr.addr] <= wr.data;
        end
    end

    assign rd_data = mem[rd_addr];

endmodule

//--- instr_decode.sv
// Stage 1: captures the word, then decodes it into a micro-op a cycle later
// MOVWF with d = 0 and any unknown word retire as NOP
`timescale 1ns/1ps
`include "pic_alu_settings.svh"

module instr_decode (
    input  logic                clk,
    input  logic                rst_n,
    input  pic_alu_pkg::instr_t instr,
    input  logic                instr_valid,
    output pic_alu_pkg::uop_t   uop
);
    import pic_alu_pkg::*;

    instr_t instr_q;
    logic   instr_vq;
    uop_t   uop_d;

    always_ff @(posedge clk) begin
        instr_q <= instr;  // Payload only
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            instr_vq <= 1'b0;
        end else begin
            instr_vq <= instr_valid;
        end
    end

    always_comb begin
        uop_d.valid  = instr_vq;
        uop_d.op     = ALU_NOP;
        uop_d.addr   = instr_q.bytef.f;
        uop_d.dest_f = instr_q.bytef.d;
        uop_d.lit    = instr_q.litf.k;

        case (instr_q.bytef.op)
            `PIC_OP_ADDWF: uop_d.op = ALU_ADDWF;
            `PIC_OP_ANDWF: uop_d.op = ALU_ANDWF;
            `PIC_OP_CLR:   uop_d.op = instr_q.bytef.d ? ALU_CLRF : ALU_CLRW;
            `PIC_OP_COMF:  uop_d.op = ALU_COMF;
            `PIC_OP_DECF:  uop_d.op = ALU_DECF;
            `PIC_OP_INCF:  uop_d.op = ALU_INCF;
            `PIC_OP_IORWF: uop_d.op = ALU_IORWF;
            `PIC_OP_MOVF:  uop_d.op = ALU_MOVF;
            `PIC_OP_MOVWF: uop_d.op = instr_q.bytef.d ? ALU_MOVWF : ALU_NOP;
            `PIC_OP_RLF:   uop_d.op = ALU_RLF;
            `PIC_OP_RRF:   uop_d.op = ALU_RRF;
            `PIC_OP_SUBWF: uop_d.op = ALU_SUBWF;
            `PIC_OP_SWAPF: uop_d.op = ALU_SWAPF;
            `PIC_OP_XORWF: uop_d.op = ALU_XORWF;
            `PIC_OP_XORLW: uop_d.op = ALU_XORLW;
            `PIC_OP_ANDLW: uop_d.op = ALU_ANDLW;
            `PIC_OP_IORLW: uop_d.op = ALU_IORLW;
            default: ;
        endcase

        case (instr_q.litf.op[5:1])
            `PIC_OP_ADDLW: uop_d.op = ALU_ADDLW;
            `PIC_OP_SUBLW: uop_d.op = ALU_SUBLW;
            default: ;
        endcase

        case (instr_q.bitf.op)
            `PIC_OP_MOVLW: uop_d.op = ALU_MOVLW;
            `PIC_OP_BCF:   uop_d.op = ALU_BCF;
            `PIC_OP_BSF:   uop_d.op = ALU_BSF;
            default: ;
        endcase

        // Literal ops always land in W
        if (instr_q.litf.op[5:4] == 2'b11) begin
            uop_d.dest_f = 1'b0;
        end

        // Bit ops modify f in place; bit 7 is part of the index here
        if (uop_d.op == ALU_BCF || uop_d.op == ALU_BSF) begin
            uop_d.dest_f = 1'b1;
            uop_d.lit    = {{(`PIC_DATA_W-`PIC_BIT_W){1'b0}}, instr_q.bitf.b};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            uop <= '0;
        end else begin
            uop <= uop_d;
        end
    end

endmodule

//--- operand_fetch.sv
// Stage 2: reads the file operand and registers it with the micro-op
// Writeback to the same address in this cycle overrides the array data,
// since the array only takes that write at the coming edge
`timescale 1ns/1ps
`include "pic_alu_settings.svh"

module operand_fetch (
    input  logic                     clk,
    input  logic                     rst_n,
    input  pic_alu_pkg::uop_t        uop,
    output logic [`PIC_FADDR_W-1:0]  rd_addr,
    input  logic [`PIC_DATA_W-1:0]   rd_data,
    input  pic_alu_pkg::file_wr_t    wb,
    output pic_alu_pkg::exec_t       ex
);

    logic                   hit;
    logic [`PIC_DATA_W-1:0] operand;

    assign rd_addr = uop.addr;

    // Write in flight to the address being fetched
    assign hit     = wb.en && (wb.addr == uop.addr);
    assign operand = hit ? wb.data : rd_data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex <= '0;
        end else begin
            ex.uop     <= uop;
            ex.operand <= operand;
        end
    end

endmodule

//--- alu_execute.sv
// Stage 3: result, flags, W and STATUS update
// The file write is combinational from the stage input and lands at the
// same edge as W and STATUS; retired rises at that edge for one cycle
// Subtracts are computed as first operand minus W, C meaning no borrow
`timescale 1ns/1ps
`include "pic_alu_settings.svh"

module alu_execute (
    input  logic                    clk,
    input  logic                    rst_n,
    input  pic_alu_pkg::exec_t      ex,
    output pic_alu_pkg::file_wr_t   wr,
    output logic [`PIC_DATA_W-1:0]  w,
    output pic_alu_pkg::status_t    status,
    output logic                    retired
);
    import pic_alu_pkg::*;

    logic                   use_lit;
    logic                   is_sub;
    logic [`PIC_DATA_W-1:0] add_a;
    logic [`PIC_DATA_W-1:0] add_b;
    logic [`PIC_DATA_W:0]   sum;
    logic [4:0]             nib;
    logic [`PIC_DATA_W-1:0] bit_mask;
    logic [`PIC_DATA_W-1:0] result;
    logic                   upd_z;
    logic                   active;
    logic                   wr_w;
    status_t                flags_nx;

    // One adder serves add and subtract, W inverted plus carry-in for subtract
    assign use_lit = (ex.uop.op == ALU_ADDLW) || (ex.uop.op == ALU_SUBLW);
    assign is_sub  = (ex.uop.op == ALU_SUBWF) || (ex.uop.op == ALU_SUBLW);
    assign add_a   = use_lit ? ex.uop.lit : ex.operand;
    assign add_b   = is_sub ? ~w : w;
    assign sum     = {1'b0, add_a} + {1'b0, add_b} + {{`PIC_DATA_W{1'b0}}, is_sub};
    assign nib     = {1'b0, add_a[3:0]} + {1'b0, add_b[3:0]} + {4'd0, is_sub};  // DC source

    always_comb begin
        bit_mask = '0;
        bit_mask[ex.uop.lit[`PIC_BIT_W-1:0]] = 1'b1;
    end

    always_comb begin
        result   = ex.operand;
        flags_nx = status;
        upd_z    = 1'b0;

        case (ex.uop.op)
            ALU_ADDWF, ALU_SUBWF, ALU_ADDLW, ALU_SUBLW: begin
                result      = sum[`PIC_DATA_W-1:0];
                flags_nx.c  = sum[`PIC_DATA_W];
                flags_nx.dc = nib[4];
                upd_z       = 1'b1;
            end
            ALU_ANDWF: begin
                result = w & ex.operand;
                upd_z  = 1'b1;
            end
            ALU_IORWF: begin
                result = w | ex.operand;
                upd_z  = 1'b1;
            end
            ALU_XORWF: begin
                result = w ^ ex.operand;
                upd_z  = 1'b1;
            end
            ALU_ANDLW: begin
                result = w & ex.uop.lit;
                upd_z  = 1'b1;
            end
            ALU_IORLW: begin
                result = w | ex.uop.lit;
                upd_z  = 1'b1;
            end
            ALU_XORLW: begin
                result = w ^ ex.uop.lit;
                upd_z  = 1'b1;
            end
            ALU_CLRF, ALU_CLRW: begin
                result = '0;
                upd_z  = 1'b1;
            end
            ALU_COMF: begin
                result = ~ex.operand;
                upd_z  = 1'b1;
            end
            ALU_DECF: begin
                result = ex.operand - 1'b1;
                upd_z  = 1'b1;
            end
            ALU_INCF: begin
                result = ex.operand + 1'b1;
                upd_z  = 1'b1;
            end
            ALU_MOVF: upd_z = 1'b1;             // Operand passes through
            ALU_MOVWF: result = w;
            ALU_RLF: begin
                result     = {ex.operand[`PIC_DATA_W-2:0], status.c};
                flags_nx.c = ex.operand[`PIC_DATA_W-1];
            end
            ALU_RRF: begin
                result     = {status.c, ex.operand[`PIC_DATA_W-1:1]};
                flags_nx.c = ex.operand[0];
            end
            ALU_SWAPF: result = {ex.operand[3:0], ex.operand[7:4]};
            ALU_BCF:   result = ex.operand & ~bit_mask;
            ALU_BSF:   result = ex.operand | bit_mask;
            ALU_MOVLW: result = ex.uop.lit;
            default: ;                          // NOP
        endcase

        if (upd_z) begin
            flags_nx.z = (result == '0);
        end
    end

    assign active = ex.uop.valid && (ex.uop.op != ALU_NOP);
    assign wr_w   = active && !ex.uop.dest_f;

    // File write goes out this cycle, operand_fetch bypasses from it
    assign wr.en   = active && ex.uop.dest_f;
    assign wr.addr = ex.uop.addr;
    assign wr.data = result;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            w       <= '0;
            status  <= '0;
            retired <= 1'b0;
        end else begin
            retired <= ex.uop.valid;    // NOPs retire too
            if (active) begin
                status <= flags_nx;
            end
            if (wr_w) begin
                w <= result;
            end
        end
    end

endmodule

//--- pic_alu_top.sv
// Accumulator ALU top: decode, operand fetch, execute plus the file array
// A word taken at edge k updates W, STATUS and the array at edge k+3
// No stall path; one word per cycle may be issued
`timescale 1ns/1ps
`include "pic_alu_settings.svh"

module pic_alu_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  pic_alu_pkg::instr_t     instr,
    input  logic                    instr_valid,
    output logic [`PIC_DATA_W-1:0]  w,
    output pic_alu_pkg::status_t    status,
    output logic                    retired
);
    import pic_alu_pkg::*;

    uop_t                    uop;
    exec_t                   ex;
    file_wr_t                wr;      // Array write and fetch bypass
    logic [`PIC_FADDR_W-1:0] rd_addr;
    logic [`PIC_DATA_W-1:0]  rd_data;

    instr_decode u_decode (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr       (instr),
        .instr_valid (instr_valid),
        .uop         (uop)
    );

    operand_fetch u_fetch (
        .clk     (clk),
        .rst_n   (rst_n),
        .uop     (uop),
        .rd_addr (rd_addr),
        .rd_data (rd_data),
        .wb      (wr),
        .ex      (ex)
    );

    file_regs u_file (
        .clk     (clk),
        .rst_n   (rst_n),
        .rd_addr (rd_addr),
        .rd_data (rd_data),
        .wr      (wr)
    );

    alu_execute u_exec (
        .clk     (clk),
        .rst_n   (rst_n),
        .ex      (ex),
        .wr      (wr),
        .w       (w),
        .status  (status),
        .retired (retired)
    );

endmodule

//--- tb_clock_gen.sv
// Testbench clock and power-on reset
// rst_n is released on a falling edge after RESET_CYCLES rising edges
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD       = 8,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

//--- tb_pic_alu.sv
// Directed tests for the accumulator ALU, checked against a behavioral model
// Inputs change on the falling edge, outputs are sampled there as well
// The model is applied in retire order, one word per retired pulse
// MOVWF is only issued with d = 1
`timescale 1ns/1ps
`include "pic_alu_settings.svh"

module tb_pic_alu;
    import pic_alu_pkg::*;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 8;
    localparam int INSTR_EST    = 400;   // Rough count of all issued words
    localparam int WATCHDOG_NS  = (RESET_CYCLES + INSTR_EST * 40) * CLK_PERIOD;

    logic        clk;
    logic        rst_n;
    instr_t      instr;
    logic        instr_valid;
    logic [7:0]  w;
    status_t     status;
    logic        retired;

    logic [7:0]  m_w;
    logic        m_z;
    logic        m_dc;
    logic        m_c;
    logic [7:0]  m_mem [128];
    logic [13:0] pending [$];             // Issued, not yet retired
    logic [31:0] lcg_state;
    int          errors;
    int          checks;
    int          tests;
    int          issued;

    tb_clock_gen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(RESET_CYCLES)) clkgen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    pic_alu_top dut0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr       (instr),
        .instr_valid (instr_valid),
        .w           (w),
        .status      (status),
        .retired     (retired)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [13:0] byte_word(input logic [5:0] op, input logic d,
                                              input logic [6:0] f);
        return {op, d, f};
    endfunction

    function automatic logic [13:0] bit_word(input logic [3:0] op, input logic [2:0] b,
                                             input logic [6:0] f);
        return {op, b, f};
    endfunction

    function automatic logic [13:0] lit_word(input logic [5:0] op, input logic [7:0] k);
        return {op, k};
    endfunction

    function automatic logic [13:0] movlw_word(input logic [7:0] k);
        return lit_word({`PIC_OP_MOVLW, 2'b00}, k);
    endfunction

    function automatic logic [13:0] addlw_word(input logic [7:0] k);
        return lit_word({`PIC_OP_ADDLW, 1'b0}, k);
    endfunction

    function automatic logic [13:0] sublw_word(input logic [7:0] k);
        return lit_word({`PIC_OP_SUBLW, 1'b0}, k);
    endfunction

    // Add or subtract against W, C and DC from the flag rules
    task automatic add_sub(input logic [7:0] a, input logic sub, output logic [7:0] res);
        logic [8:0] wide;
        if (sub) begin
            res  = a - m_w;
            m_c  = (a >= m_w);               // No borrow
            m_dc = (a[3:0] >= m_w[3:0]);
        end else begin
            wide = {1'b0, a} + {1'b0, m_w};
            res  = wide[7:0];
            m_c  = wide[8];
            m_dc = (({1'b0, a[3:0]} + {1'b0, m_w[3:0]}) > 5'd15);
        end
    endtask

    task automatic apply_model(input logic [13:0] word);
        logic [5:0] op;
        logic       d;
        logic [6:0] f;
        logic [7:0] a;
        logic [7:0] res;
        logic [7:0] mask;
        logic       to_w;
        logic       to_f;
        logic       set_z;
        op    = word[13:8];
        d     = word[7];
        f     = word[6:0];
        a     = m_mem[f];
        res   = a;
        mask  = 8'h01 << word[9:7];
        to_w  = 1'b0;
        to_f  = 1'b0;
        set_z = 1'b0;
        if (word[13:10] == `PIC_OP_MOVLW) begin
            res  = word[7:0];
            to_w = 1'b1;
        end else if (word[13:10] == `PIC_OP_BSF) begin
            res  = a | mask;
            to_f = 1'b1;
        end else if (word[13:10] == `PIC_OP_BCF) begin
            res  = a & ~mask;
            to_f = 1'b1;
        end else if (word[13:9] == `PIC_OP_ADDLW || word[13:9] == `PIC_OP_SUBLW) begin
            add_sub(word[7:0], word[13:9] == `PIC_OP_SUBLW, res);
            to_w  = 1'b1;
            set_z = 1'b1;
        end else begin
            to_w  = !d;
            to_f  = d;
            set_z = 1'b1;
            case (op)
                `PIC_OP_ADDWF: add_sub(a, 1'b0, res);
                `PIC_OP_SUBWF: add_sub(a, 1'b1, res);
                `PIC_OP_ANDWF: res = m_w & a;
                `PIC_OP_IORWF: res = m_w | a;
                `PIC_OP_XORWF: res = m_w ^ a;
                `PIC_OP_CLR:   res = 8'h00;
                `PIC_OP_COMF:  res = ~a;
                `PIC_OP_DECF:  res = a - 8'd1;
                `PIC_OP_INCF:  res = a + 8'd1;
                `PIC_OP_MOVF:  res = a;
                `PIC_OP_ANDLW, `PIC_OP_IORLW, `PIC_OP_XORLW: begin
                    res  = (op == `PIC_OP_ANDLW) ? (m_w & word[7:0]) :
                           (op == `PIC_OP_IORLW) ? (m_w | word[7:0]) : (m_w ^ word[7:0]);
                    to_w = 1'b1;
                    to_f = 1'b0;
                end
                `PIC_OP_RLF: begin
                    res   = {a[6:0], m_c};
                    m_c   = a[7];
                    set_z = 1'b0;
                end
                `PIC_OP_RRF: begin
                    res   = {m_c, a[7:1]};
                    m_c   = a[0];
                    set_z = 1'b0;
                end
                `PIC_OP_SWAPF: begin
                    res   = {a[3:0], a[7:4]};
                    set_z = 1'b0;
                end
                `PIC_OP_MOVWF: begin
                    res   = m_w;
                    to_w  = 1'b0;            // d = 0 is not a store
                    set_z = 1'b0;
                end
                default: begin               // Unknown words do nothing
                    to_w  = 1'b0;
                    to_f  = 1'b0;
                    set_z = 1'b0;
                end
            endcase
        end
        if (set_z) m_z = (res == 8'h00);
        if (to_w) m_w = res;
        if (to_f) m_mem[f] = res;
    endtask

    task automatic check_eq(input logic [7:0] got, input logic [7:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            $display("FAIL %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic handle_retire();
        logic [13:0] word;
        if (pending.size() == 0) begin
            $display("Retire pulse at %0t with no instruction in flight", $time);
            errors++;
        end else begin
            word = pending.pop_front();
            apply_model(word);
            check_eq(w, m_w, $sformatf("W after %h", word));
            check_eq({5'd0, status}, {5'd0, m_z, m_dc, m_c}, $sformatf("STATUS after %h", word));
        end
    endtask

    // One clock: retire check first, then the next input
    task automatic clock_cycle(input logic valid, input logic [13:0] word);
        @(negedge clk);
        if (retired) handle_retire();
        instr       = word;
        instr_valid = valid;
        if (valid) begin
            pending.push_back(word);
            issued++;
        end
    endtask

    task automatic issue(input logic [13:0] word);
        clock_cycle(1'b1, word);
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (pending.size() != 0 && waited < 8) begin
            clock_cycle(1'b0, 14'h0000);
            waited++;
        end
        if (pending.size() != 0) begin
            $display("Timed out at %0t waiting for %0d retire pulses", $time, pending.size());
            errors++;
            pending.delete();
        end
        clock_cycle(1'b0, 14'h0000);         // Catches a stray retire
    endtask

    task automatic report_test(input string name, input int start_errors);
        tests++;
        $display("%s finished with %0d errors", name, errors - start_errors);
    endtask

    task automatic literal_ops_test();
        int start_errors;
        start_errors = errors;
        issue(movlw_word(8'h3c));
        issue(addlw_word(8'hc4));            // Zero with C and DC
        issue(addlw_word(8'h0f));
        issue(addlw_word(8'h09));            // Half carry only
        issue(sublw_word(8'h10));            // Borrow
        issue(sublw_word(8'hff));
        issue(sublw_word(8'h07));            // Zero result
        issue(lit_word(`PIC_OP_ANDLW, 8'h00));
        issue(lit_word(`PIC_OP_IORLW, 8'ha5));
        issue(lit_word(`PIC_OP_XORLW, 8'ha5));
        issue(lit_word(`PIC_OP_XORLW, 8'h5a));
        issue(lit_word(`PIC_OP_ANDLW, 8'h0f));
        issue(movlw_word(8'h00));            // Z untouched
        drain();
        report_test("literal ops", start_errors);
    endtask

    task automatic store_reload_test();
        int         start_errors;
        logic [6:0] addrs [6];
        start_errors = errors;
        addrs = '{7'h05, 7'h20, 7'h7f, 7'h00, 7'h41, 7'h13};
        for (int i = 0; i < 6; i++) begin
            issue(movlw_word(8'h0b + 8'(i * 37)));
            issue(byte_word(`PIC_OP_MOVWF, 1'b1, addrs[i]));
        end
        issue(movlw_word(8'h00));
        for (int i = 0; i < 6; i++) begin
            issue(byte_word(`PIC_OP_MOVF, 1'b0, addrs[i]));
        end
        // Reload right behind the store
        issue(movlw_word(8'h99));
        issue(byte_word(`PIC_OP_MOVWF, 1'b1, 7'h30));
        issue(byte_word(`PIC_OP_MOVF, 1'b0, 7'h30));
        issue(movlw_word(8'h00));
        issue(byte_word(`PIC_OP_MOVWF, 1'b1, 7'h30));
        issue(byte_word(`PIC_OP_MOVF, 1'b1, 7'h30));
        issue(byte_word(`PIC_OP_MOVF, 1'b0, 7'h05));
        drain();
        report_test("store and reload", start_errors);
    endtask

    task automatic byte_ops_test();
        int         start_errors;
        logic [5:0] ops [8];
        logic [6:0] f;
        start_errors = errors;
        ops = '{`PIC_OP_ADDWF, `PIC_OP_SUBWF, `PIC_OP_ANDWF, `PIC_OP_IORWF,
                `PIC_OP_XORWF, `PIC_OP_INCF, `PIC_OP_DECF, `PIC_OP_COMF};
        issue(movlw_word(8'h5a));
        issue(byte_word(`PIC_OP_MOVWF, 1'b1, 7'h10));
        issue(movlw_word(8'hf0));
        issue(byte_word(`PIC_OP_MOVWF, 1'b1, 7'h11));
        for (int i = 0; i < 8; i++) begin
            for (int d = 0; d < 2; d++) begin
                f = (d == 1) ? 7'h11 : 7'h10;
                issue(movlw_word(8'h37 + 8'(i * 9)));
                issue(byte_word(ops[i], d == 1, f));
                issue(byte_word(`PIC_OP_MOVF, 1'b0, f));
            end
        end
        // Wrap to zero on increment and decrement
        issue(movlw_word(8'hff));
        issue(byte_word(`PIC_OP_MOVWF, 1'b1, 7'h14));
        issue(byte_word(`PIC_OP_INCF, 1'b1, 7'h14));
        issue(movlw_word(8'h01));
        issue(byte_word(`PIC_OP_MOVWF, 1'b1, 7'h15));
        issue(byte_word(`PIC_OP_DECF, 1'b0, 7'h15));
        issue(byte_word(`PIC_OP_CLR, 1'b1, 7'h10));      // CLRF
        issue(byte_word(`PIC_OP_MOVF, 1'b0, 7'h10));
        issue(movlw_word(8'h77));
        issue(byte_word(`PIC_OP_CLR, 1'b0, 7'h00));      // CLRW
        drain();
        report_test("byte arithmetic and logic", start_errors);
    endtask

    task automatic rotate_swap_test();
        int start_errors;
        start_errors = errors;
        issue(movlw_word(8'h81));
        issue(byte_word(`PIC_OP_MOVWF, 1'b1, 7'h20));
        repeat (9) issue(byte_word(`PIC_OP_RLF, 1'b1, 7'h20));
        issue(byte_word(`PIC_OP_MOVF, 1'b0, 7'h20));
        repeat (9) issue(byte_word(`PIC_OP_RRF, 1'b1, 7'h20));
        issue(byte_word(`PIC_OP_RRF, 1'b0, 7'h20));
        issue(byte_word(`PIC_OP_RLF, 1'b0, 7'h20));
        issue(movlw_word(8'h3c));
        issue(byte_word(`PIC_OP_MOVWF, 1'b1, 7'h21));
        issue(byte_word(`PIC_OP_SWAPF, 1'b0, 7'h21));
        issue(byte_word(`PIC_OP_SWAPF, 1'b1, 7'h21));
        issue(byte_word(`PIC_OP_MOVF, 1'b0, 7'h21));
        drain();
        report_test("rotate and swap", start_errors);
    endtask

    task automatic bit_ops_test();
        int start_errors;
        start_errors = errors;
        issue(movlw_word(8'h00));
        issue(byte_word(`PIC_OP_MOVWF, 1'b1, 7'h33));
        for (int b = 0; b < 8; b++) begin
            issue(bit_word(`PIC_OP_BSF, 3'(b), 7'h33));
            issue(byte_word(`PIC_OP_MOVF, 1'b0, 7'h33));
        end
        for (int b = 0; b < 8; b++) begin
            issue(bit_word(`PIC_OP_BCF, 3'(b), 7'h33));
            issue(byte_word(`PIC_OP_MOVF, 1'b0, 7'h33));
        end
        drain();
        report_test("bit set and clear", start_errors);
    endtask

    function automatic logic [13:0] random_word(input logic [31:0] r);
        logic [6:0] f;
        logic       d;
        logic [7:0] k;
        f = {3'b100, r[11:8]};               // 16 addresses
        d = r[12];
        k = r[23:16];
        case (int'(r[31:24]) % 22)
            0:  return byte_word(`PIC_OP_ADDWF, d, f);
            1:  return byte_word(`PIC_OP_ANDWF, d, f);
            2:  return byte_word(`PIC_OP_CLR, d, f);
            3:  return byte_word(`PIC_OP_COMF, d, f);
            4:  return byte_word(`PIC_OP_DECF, d, f);
            5:  return byte_word(`PIC_OP_INCF, d, f);
            6:  return byte_word(`PIC_OP_IORWF, d, f);
            7:  return byte_word(`PIC_OP_MOVF, d, f);
            8:  return byte_word(`PIC_OP_MOVWF, 1'b1, f);
            9:  return byte_word(`PIC_OP_RLF, d, f);
            10: return byte_word(`PIC_OP_RRF, d, f);
            11: return byte_word(`PIC_OP_SUBWF, d, f);
            12: return byte_word(`PIC_OP_SWAPF, d, f);
            13: return byte_word(`PIC_OP_XORWF, d, f);
            14: return bit_word(`PIC_OP_BCF, r[15:13], f);
            15: return bit_word(`PIC_OP_BSF, r[15:13], f);
            16: return movlw_word(k);
            17: return addlw_word(k);
            18: return sublw_word(k);
            19: return lit_word(`PIC_OP_ANDLW, k);
            20: return lit_word(`PIC_OP_IORLW, k);
            default: return lit_word(`PIC_OP_XORLW, k);
        endcase
    endfunction

    task automatic random_stream_test();
        int start_errors;
        start_errors = errors;
        for (int i = 0; i < 200; i++) begin
            lcg_state = lcg_next(lcg_state);
            issue(random_word(lcg_state));   // No gaps
        end
        drain();
        report_test("random stream", start_errors);
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the run timed out", WATCHDOG_NS);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        instr       = '0;
        instr_valid = 1'b0;
        m_w         = 8'h00;
        m_z         = 1'b0;
        m_dc        = 1'b0;
        m_c         = 1'b0;
        lcg_state   = 32'hc634979e;
        errors      = 0;
        checks      = 0;
        tests       = 0;
        issued      = 0;
        for (int i = 0; i < 128; i++) begin
            m_mem[i] = 8'h00;
        end
        wait (rst_n === 1'b1);

        literal_ops_test();
        store_reload_test();
        byte_ops_test();
        rotate_swap_test();
        bit_ops_test();
        random_stream_test();

        $display("%0d tests, %0d instructions, %0d checks, %0d errors",
                 tests, issued, checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- list.f
+incdir+.
pic_alu_pkg.sv
file_regs.sv
instr_decode.sv
operand_fetch.sv
alu_execute.sv
pic_alu_top.sv
tb_clock_gen.sv
tb_pic_alu.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the ALU testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_pic_alu -f list.f -o tb_pic_alu_sim
out=$(./obj_dir/tb_pic_alu_sim)
echo "$out"

if grep -qx "NO ERRORS" <<< "$out"; then
    exit 0
fi
exit 1
